// ==== files.f ====
matrix_pkg.sv
mem_if.sv
uart_rx.sv
num_parser.sv
matrix_ctrl.sv
matrix_store.sv
dec_printer.sv
uart_tx.sv
matrix_calc_top.sv
tb_matrix_calc_assert.sv
tb_matrix_calc.sv

// ==== Makefile ====
# Verilator build and run of the matrix calculator testbench

VERILATOR ?= verilator
TOP       ?= tb_matrix_calc
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
# Keep running past assertion errors so the testbench reports the result
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_matrix_calc.sv ====
`timescale 1ns/1ns

module tb_matrix_calc;

    localparam int CLK_NS      = 8;
    localparam int BIT_CLKS    = 10;    // 125 MHz over 12.5 MBd
    localparam int TEST_CHARS  = 4000;  // Chars in and out over all tests, rounded up
    localparam int WATCHDOG_NS = TEST_CHARS * 10 * BIT_CLKS * CLK_NS + 100_000;
    localparam int PRINT_LIMIT = 60_000;  // Cycles, 7x7 of widest values

    logic              clk;
    logic              rst_n;
    logic              rxd;
    logic              btn_load;
    logic              btn_print;
    matrix_pkg::slot_t slot_sel;
    logic              txd;
    logic              busy;

    matrix_pkg::byte_t tx_q [$];      // Characters captured from txd
    matrix_pkg::elem_t model_q [$];   // Expected elements, row by row
    matrix_pkg::elem_t parsed_q [$];  // Printed text read back

    matrix_calc_top #(.CLK_FREQ(125_000_000), .BAUD_RATE(12_500_000)) matrix_calc_top_inst (
        .clk(clk), .rst_n(rst_n), .rxd(rxd), .btn_load(btn_load), .btn_print(btn_print),
        .slot_sel(slot_sel), .txd(txd), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ----------------------------------------------------------
    // Failure and compare
    // ----------------------------------------------------------
    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_byte(input string name, input matrix_pkg::byte_t got,
                              input matrix_pkg::byte_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_elem(input string name, input matrix_pkg::elem_t got,
                              input matrix_pkg::elem_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    // ----------------------------------------------------------
    // Bus helpers
    // ----------------------------------------------------------
    task automatic tick(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            n++;
            tick(1);
        end
        if (busy !== level) begin
            $display("Error: busy never went %0b while %s", level, what);
            fail_run();
        end
    endtask

    task automatic uart_send(input matrix_pkg::byte_t c);
        rxd = 1'b0;  // Start bit
        tick(BIT_CLKS);
        for (int i = 0; i < 8; i++) begin
            rxd = c[i];  // LSB first
            tick(BIT_CLKS);
        end
        rxd = 1'b1;  // Stop bit
        tick(BIT_CLKS);
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            uart_send(matrix_pkg::byte_t'(s[i]));
        end
    endtask

    // One character off txd, sampled mid-bit
    task automatic uart_capture();
        matrix_pkg::byte_t b;
        @(negedge clk);
        if (txd === 1'b0) begin
            tick(BIT_CLKS / 2);  // Centre of start bit
            for (int i = 0; i < 8; i++) begin
                tick(BIT_CLKS);
                b[i] = txd;
            end
            tick(BIT_CLKS);
            if (txd !== 1'b1) begin
                $display("Error: transmitted character ended without a stop bit");
                fail_run();
            end else begin
                tx_q.push_back(b);
            end
        end
    endtask

    initial forever uart_capture();

    // Hold the button until the controller answers
    task automatic press_button(input logic is_print, input matrix_pkg::slot_t slot);
        slot_sel  = slot;
        btn_load  = !is_print;
        btn_print = is_print;
        wait_busy(1'b1, 8, "taking a button edge");
        btn_load  = 1'b0;
        btn_print = 1'b0;
        tick(2);
    endtask

    task automatic load_slot(input matrix_pkg::slot_t slot, input string text);
        press_button(1'b0, slot);
        send_text(text);
        wait_busy(1'b0, 4 * BIT_CLKS, "storing the last element");
    endtask

    // Printed text back into values, '-' digits ' '
    task automatic parse_back();
        int acc;
        bit neg;
        acc = 0;
        neg = 1'b0;
        parsed_q.delete();
        foreach (tx_q[i]) begin
            if (tx_q[i] == 8'h2D) begin
                neg = 1'b1;
            end else if (tx_q[i] == 8'h20) begin
                parsed_q.push_back(matrix_pkg::elem_t'(neg ? -acc : acc));
                acc = 0;
                neg = 1'b0;
            end else begin
                acc = acc * 10 + int'(tx_q[i]) - 48;
            end
        end
    endtask

    // Print a slot and compare with model_q, signed decimal plus space each
    task automatic print_check(input matrix_pkg::slot_t slot);
        matrix_pkg::byte_t exp_q [$];
        string             s;
        foreach (model_q[i]) begin
            s = $sformatf("%0d ", model_q[i]);
            for (int k = 0; k < s.len(); k++) begin
                exp_q.push_back(matrix_pkg::byte_t'(s[k]));
            end
        end
        tx_q.delete();
        press_button(1'b1, slot);
        wait_busy(1'b0, PRINT_LIMIT, "printing");
        tick(BIT_CLKS);  // Stays idle after done
        check_bit("busy", busy, 1'b0);
        check_bit("txd", txd, 1'b1);
        // Values first, then the exact text
        parse_back();
        if (parsed_q.size() != model_q.size()) begin
            $display("Error: slot %0d printed %0d values instead of %0d",
                     slot, parsed_q.size(), model_q.size());
            fail_run();
        end
        foreach (model_q[i]) check_elem($sformatf("elem %0d", i), parsed_q[i], model_q[i]);
        if (tx_q.size() != exp_q.size()) begin
            $display("Error: slot %0d printed %0d characters instead of %0d",
                     slot, tx_q.size(), exp_q.size());
            fail_run();
        end
        foreach (exp_q[i]) check_byte($sformatf("txd char %0d", i), tx_q[i], exp_q[i]);
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------
    task automatic test_reset_idle();
        for (int i = 0; i < 6; i++) begin
            check_bit("txd", txd, 1'b1);
            check_bit("busy", busy, 1'b0);
            tick(1);
        end
    endtask

    task automatic test_basic_load();
        load_slot(2'd1, "2 3 1 2 3 4 5 6 ");
        model_q = '{16'sd1, 16'sd2, 16'sd3, 16'sd4, 16'sd5, 16'sd6};
        print_check(2'd1);
    endtask

    task automatic test_signed_values();
        load_slot(2'd1, "2 3 -7 0 32767 -32768 40000 10 ");
        model_q = '{-16'sd7, 16'sd0, 16'sd32767, 16'sh8000, -16'sd25536, 16'sd10};  // Wraps
        print_check(2'd1);
    endtask

    task automatic test_separators();
        load_slot(2'd2, "\015\n0 3  2\015\n7 -8\015\n9 10 \n11  12\n");  // 0 skipped
        model_q = '{16'sd7, -16'sd8, 16'sd9, 16'sd10, 16'sd11, 16'sd12};
        print_check(2'd2);
    endtask

    task automatic test_slots();
        load_slot(2'd0, "1 2 -5 5 ");
        load_slot(2'd2, "2 2 100 -200 300 -400 ");
        model_q = '{-16'sd5, 16'sd5};
        print_check(2'd0);
        model_q = '{16'sd100, -16'sd200, 16'sd300, -16'sd400};
        print_check(2'd2);
        model_q.delete();  // Slot 3 never loaded
        print_check(2'd3);
    endtask

    task automatic test_random();
        int                m;
        int                n;
        matrix_pkg::slot_t slot;
        matrix_pkg::elem_t v;
        string             text;
        for (int r = 0; r < 4; r++) begin
            m    = int'($urandom_range(7, 1));
            n    = int'($urandom_range(7, 1));
            slot = matrix_pkg::slot_t'($urandom_range(2, 0));
            text = $sformatf("%0d %0d ", m, n);
            model_q.delete();
            for (int i = 0; i < m * n; i++) begin
                v = matrix_pkg::elem_t'($urandom);
                model_q.push_back(v);
                text = {text, $sformatf("%0d ", v)};
            end
            load_slot(slot, text);
            print_check(slot);
        end
    endtask

    function automatic int assert_failures();
        return matrix_calc_top_inst.u_tx.tx_chk.start_fails
             + matrix_calc_top_inst.u_tx.tx_chk.idle_fails
             + matrix_calc_top_inst.u_ctrl.ctrl_chk.start_fails
             + matrix_calc_top_inst.u_ctrl.ctrl_chk.idle_fails;
    endfunction

    // Bound assertion failures stop the run at once
    always @(negedge clk) begin
        if (assert_failures() != 0) begin
            $display("Error: %0d bound assertions failed", assert_failures());
            fail_run();
        end
    end

    // ----------------------------------------------------------
    // Sequence and watchdog
    // ----------------------------------------------------------
    initial begin
        void'($urandom(32'h9fe));  // One seed for the run
        rst_n     = 1'b0;
        rxd       = 1'b1;  // Idle mark
        btn_load  = 1'b0;
        btn_print = 1'b0;
        slot_sel  = '0;
        tick(3);
        rst_n = 1'b1;
        test_reset_idle();
        test_basic_load();
        test_signed_values();
        test_separators();
        test_slots();
        test_random();
        tick(5);
        if (assert_failures() != 0) begin
            $display("Error: %0d bound assertions failed", assert_failures());
            fail_run();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: run did not finish within %0d ns", WATCHDOG_NS);
        fail_run();
    end

endmodule

// ==== tb_matrix_calc_assert.sv ====
`timescale 1ns/1ns

// Start/busy protocol checks, one instance per bound module
module tb_matrix_calc_assert (
    input logic clk,
    input logic rst_n,
    input logic start,     // Single-cycle request
    input logic busy,      // Level while working
    input logic idle_high  // Must stay high while not busy
);
    int start_fails = 0;  // Failure counts per property
    int idle_fails  = 0;

    // No new request while the previous one is running
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else begin
            start_fails++;
            $error("start pulse while busy");
        end

    // Idle level holds while not busy
    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> idle_high)
        else begin
            idle_fails++;
            $error("idle signal low while not busy");
        end

endmodule

// ----------------------------------------------------------
// Attach to transmitter and controller
// ----------------------------------------------------------
bind uart_tx tb_matrix_calc_assert tx_chk (  // Line at mark level when idle
    .clk(clk), .rst_n(rst_n), .start(tx_start), .busy(tx_busy), .idle_high(txd)
);

bind matrix_ctrl tb_matrix_calc_assert ctrl_chk (  // Printer done only while printing
    .clk(clk), .rst_n(rst_n), .start(print_start), .busy(busy), .idle_high(!print_done)
);

// ==== matrix_calc_top.sv ====
`timescale 1ns/1ns

module matrix_calc_top #(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rxd,
    input  logic              btn_load,
    input  logic              btn_print,
    input  matrix_pkg::slot_t slot_sel,
    output logic              txd,
    output logic              busy
);
    matrix_pkg::byte_t     rx_byte;
    logic                  rx_valid;
    matrix_pkg::num_word_u num;
    logic                  num_valid;
    logic                  print_start;
    matrix_pkg::slot_t     print_slot;
    logic                  print_done;
    matrix_pkg::byte_t     tx_data;
    logic                  tx_start;
    logic                  tx_busy;

    mem_wr_if wr_bus ();
    mem_rd_if rd_bus ();

    // ----------------------------------------------------------
    // Input side
    // ----------------------------------------------------------
    uart_rx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_rx (
        .clk(clk), .rst_n(rst_n), .rxd(rxd), .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    num_parser u_parser (
        .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .num(num), .num_valid(num_valid)
    );

    // ----------------------------------------------------------
    // Control and storage
    // ----------------------------------------------------------
    matrix_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .btn_load(btn_load), .btn_print(btn_print),
        .slot_sel(slot_sel), .num(num), .num_valid(num_valid),
        .print_done(print_done), .busy(busy), .print_start(print_start),
        .print_slot(print_slot), .wr(wr_bus)
    );

    matrix_store u_store (.clk(clk), .rst_n(rst_n), .wr(wr_bus), .rd(rd_bus));

    // ----------------------------------------------------------
    // Output side
    // ----------------------------------------------------------
    dec_printer u_printer (
        .clk(clk), .rst_n(rst_n), .print_start(print_start), .print_slot(print_slot),
        .tx_busy(tx_busy), .print_done(print_done), .tx_data(tx_data),
        .tx_start(tx_start), .rd(rd_bus)
    );

    uart_tx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_tx (
        .clk(clk), .rst_n(rst_n), .tx_data(tx_data), .tx_start(tx_start),
        .txd(txd), .tx_busy(tx_busy)
    );

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic              clk,
    input  logic              rst_n,
    input  matrix_pkg::byte_t tx_data,
    input  logic              tx_start,
    output logic              txd,
    output logic              tx_busy
);
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;  // 0 start, 1..8 data, 9 stop
    logic [8:0]       shreg;    // {stop, data}

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txd     <= 1'b1;
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shreg   <= '1;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shreg   <= {1'b1, tx_data};
                txd     <= 1'b0;  // Start bit
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;  // End of stop bit, line stays high
            end else begin
                txd     <= shreg[0];  // LSB first
                shreg   <= {1'b1, shreg[8:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

// ==== dec_printer.sv ====
`timescale 1ns/1ns

module dec_printer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              print_start,
    input  matrix_pkg::slot_t print_slot,
    input  logic              tx_busy,
    output logic              print_done,
    output matrix_pkg::byte_t tx_data,
    output logic              tx_start,
    mem_rd_if.reader          rd
);
    typedef enum logic [2:0] {
        S_IDLE, S_READ, S_LATCH, S_DIV, S_SIGN, S_DIGIT, S_SPACE, S_FLUSH
    } state_t;

    state_t           state;
    matrix_pkg::dim_t row;
    matrix_pkg::dim_t col;
    logic [15:0]      mag;       // Unsigned, holds 32768
    logic             neg;
    logic [3:0]       digits [matrix_pkg::MAX_DIGITS];  // [0] is ones
    logic [2:0]       dcnt;
    logic [2:0]       top;       // Highest nonzero digit
    logic [2:0]       idx;
    logic             can_send;

    assign rd.slot  = print_slot;  // Held by controller while printing
    assign rd.row   = row;
    assign rd.col   = col;
    assign can_send = !tx_busy && !tx_start;  // Busy lags start by one

    // ----------------------------------------------------------
    // Element walk and character sequencing
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            row        <= '0;
            col        <= '0;
            mag        <= '0;
            neg        <= 1'b0;
            dcnt       <= '0;
            top        <= '0;
            idx        <= '0;
            tx_data    <= '0;
            tx_start   <= 1'b0;
            print_done <= 1'b0;
        end else begin
            tx_start   <= 1'b0;
            print_done <= 1'b0;
            case (state)
                S_IDLE: if (print_start) begin
                    row <= '0;
                    col <= '0;
                    if (rd.dim_m == '0 || rd.dim_n == '0) print_done <= 1'b1;  // Empty slot
                    else state <= S_READ;
                end
                S_READ: state <= S_LATCH;  // Wait for registered read
                S_LATCH: begin
                    neg   <= rd.rdata[15];
                    mag   <= rd.rdata[15] ? 16'(-rd.rdata) : 16'(rd.rdata);
                    dcnt  <= '0;
                    top   <= '0;
                    state <= S_DIV;
                end
                S_DIV: begin
                    mag  <= mag / 16'd10;
                    dcnt <= dcnt + 1'b1;
                    if (mag % 16'd10 != '0) top <= dcnt;
                    if (dcnt == 3'(matrix_pkg::MAX_DIGITS - 1)) state <= S_SIGN;
                end
                S_SIGN: begin
                    idx <= top;
                    if (!neg) begin
                        state <= S_DIGIT;
                    end else if (can_send) begin
                        tx_data  <= matrix_pkg::CHAR_MINUS;
                        tx_start <= 1'b1;
                        state    <= S_DIGIT;
                    end
                end
                S_DIGIT: if (can_send) begin  // Most significant first
                    tx_data  <= matrix_pkg::CHAR_ZERO + {4'b0, digits[idx]};
                    tx_start <= 1'b1;
                    if (idx == '0) state <= S_SPACE;
                    else idx <= idx - 1'b1;
                end
                S_SPACE: if (can_send) begin
                    tx_data  <= matrix_pkg::CHAR_SPACE;
                    tx_start <= 1'b1;
                    state    <= S_READ;
                    if (col == rd.dim_n - 1'b1) begin
                        col <= '0;
                        row <= row + 1'b1;
                        if (row == rd.dim_m - 1'b1) state <= S_FLUSH;  // Last element
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                S_FLUSH: if (can_send) begin  // Last stop bit out
                    print_done <= 1'b1;
                    state      <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Digit buffer, filled ones first
    always_ff @(posedge clk) begin
        if (state == S_DIV) digits[dcnt] <= 4'(mag % 16'd10);
    end

endmodule

// ==== matrix_store.sv ====
`timescale 1ns/1ns

module matrix_store (
    input logic     clk,
    input logic     rst_n,
    mem_wr_if.store wr,
    mem_rd_if.store rd
);
    matrix_pkg::elem_t mem [256];  // {slot, row, col}
    matrix_pkg::dim_t  dim_m [4];
    matrix_pkg::dim_t  dim_n [4];

    // Element array, registered read
    always_ff @(posedge clk) begin
        if (wr.we) mem[{wr.slot, wr.row, wr.col}] <= wr.wdata;
        rd.rdata <= mem[{rd.slot, rd.row, rd.col}];
    end

    // Per-slot dimensions, empty after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                dim_m[i] <= '0;
                dim_n[i] <= '0;
            end
        end else if (wr.dim_we) begin
            dim_m[wr.slot] <= wr.dim_m;
            dim_n[wr.slot] <= wr.dim_n;
        end
    end

    assign rd.dim_m = dim_m[rd.slot];
    assign rd.dim_n = dim_n[rd.slot];

endmodule

// ==== matrix_ctrl.sv ====
`timescale 1ns/1ns

module matrix_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  btn_load,
    input  logic                  btn_print,
    input  matrix_pkg::slot_t     slot_sel,
    input  matrix_pkg::num_word_u num,
    input  logic                  num_valid,
    input  logic                  print_done,
    output logic                  busy,
    output logic                  print_start,
    output matrix_pkg::slot_t     print_slot,
    mem_wr_if.ctrl                wr
);
    typedef enum logic [1:0] {S_IDLE, S_DIM, S_DATA, S_PRINT} state_t;

    state_t            state;
    logic [1:0]        load_q;   // [0] sample, [1] previous
    logic [1:0]        print_q;
    logic              load_edge;
    logic              print_edge;
    matrix_pkg::slot_t slot;
    matrix_pkg::dim_t  m_cnt;    // Zero until first dimension
    matrix_pkg::dim_t  n_cnt;
    matrix_pkg::dim_t  row;
    matrix_pkg::dim_t  col;

    assign load_edge  = load_q[0] & ~load_q[1];
    assign print_edge = print_q[0] & ~print_q[1];

    assign busy        = (state != S_IDLE);
    assign print_start = print_edge && !load_edge && (state == S_IDLE);  // Load wins
    assign print_slot  = (state == S_IDLE) ? slot_sel : slot;
    assign wr.slot     = slot;

    // ----------------------------------------------------------
    // Entry FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            load_q    <= '0;
            print_q   <= '0;
            slot      <= '0;
            m_cnt     <= '0;
            n_cnt     <= '0;
            row       <= '0;
            col       <= '0;
            wr.we     <= 1'b0;
            wr.dim_we <= 1'b0;
        end else begin
            load_q    <= {load_q[0], btn_load};
            print_q   <= {print_q[0], btn_print};
            wr.we     <= 1'b0;
            wr.dim_we <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (load_edge) begin
                        slot  <= slot_sel;
                        m_cnt <= '0;
                        state <= S_DIM;
                    end else if (print_edge) begin
                        slot  <= slot_sel;
                        state <= S_PRINT;
                    end
                end
                S_DIM: if (num_valid && num.dw.dim != '0) begin  // Zero dims skipped
                    if (m_cnt == '0) begin
                        m_cnt <= num.dw.dim;
                    end else begin
                        n_cnt     <= num.dw.dim;
                        wr.dim_we <= 1'b1;
                        row       <= '0;
                        col       <= '0;
                        state     <= S_DATA;
                    end
                end
                S_DATA: if (num_valid) begin
                    wr.we <= 1'b1;
                    if (col == n_cnt - 1'b1) begin  // Row complete
                        col <= '0;
                        if (row == m_cnt - 1'b1) state <= S_IDLE;
                        else row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                S_PRINT: if (print_done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Write payload, qualified by we/dim_we one cycle later
    always_ff @(posedge clk) begin
        wr.row   <= row;
        wr.col   <= col;
        wr.wdata <= num.elem;
        wr.dim_m <= m_cnt;
        wr.dim_n <= num.dw.dim;  // Second dimension arrives with dim_we
    end

endmodule

// ==== num_parser.sv ====
`timescale 1ns/1ns

module num_parser (
    input  logic                  clk,
    input  logic                  rst_n,
    input  matrix_pkg::byte_t     rx_byte,
    input  logic                  rx_valid,
    output matrix_pkg::num_word_u num,
    output logic                  num_valid
);
    logic [15:0] acc;        // Magnitude, wraps mod 2^16
    logic        neg;
    logic        have_digit;
    logic        is_digit;
    logic [3:0]  digit;

    assign is_digit = (rx_byte >= matrix_pkg::CHAR_ZERO) &&
                      (rx_byte <= matrix_pkg::CHAR_ZERO + 8'd9);
    assign digit    = 4'(rx_byte - matrix_pkg::CHAR_ZERO);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc        <= '0;
            neg        <= 1'b0;
            have_digit <= 1'b0;
            num        <= '0;
            num_valid  <= 1'b0;
        end else begin
            num_valid <= 1'b0;
            if (rx_valid) begin
                if (is_digit) begin
                    acc        <= acc * 16'd10 + 16'(digit);
                    have_digit <= 1'b1;
                end else if (rx_byte == matrix_pkg::CHAR_MINUS && !have_digit) begin
                    neg <= 1'b1;  // Sign only before first digit
                end else begin
                    // Any separator ends the number
                    if (have_digit) begin
                        num.elem  <= neg ? -$signed(acc) : $signed(acc);
                        num_valid <= 1'b1;
                    end
                    acc        <= '0;
                    neg        <= 1'b0;  // Lone minus forgotten
                    have_digit <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx #(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rxd,
    output matrix_pkg::byte_t rx_byte,
    output logic              rx_valid
);
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t            state;
    logic [1:0]        rx_sync;   // Two-flop synchronizer
    logic [CNT_W-1:0]  clk_cnt;
    logic [2:0]        bit_cnt;
    matrix_pkg::byte_t shreg;
    logic              rx_s;

    assign rx_s = rx_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            rx_sync  <= 2'b11;  // Line idles high
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            shreg    <= '0;
            rx_byte  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rxd};
            rx_valid <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_s) state <= S_START;  // Falling edge of start bit
                end
                S_START: if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= rx_s ? S_IDLE : S_DATA;  // Glitch rejected
                end
                S_DATA: if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    clk_cnt <= '0;
                    shreg   <= {rx_s, shreg[7:1]};  // LSB first
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= S_STOP;
                end
                S_STOP: if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    state <= S_IDLE;
                    if (rx_s) begin  // Framing error drops byte
                        rx_byte  <= shreg;
                        rx_valid <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== mem_if.sv ====
`timescale 1ns/1ns

// Write side of the matrix store, elements and dimensions
interface mem_wr_if;
    matrix_pkg::slot_t slot;
    matrix_pkg::dim_t  row;
    matrix_pkg::dim_t  col;
    matrix_pkg::elem_t wdata;
    logic              we;      // Single-cycle element write
    matrix_pkg::dim_t  dim_m;
    matrix_pkg::dim_t  dim_n;
    logic              dim_we;  // Single-cycle dimension write

    modport ctrl  (output slot, row, col, wdata, we, dim_m, dim_n, dim_we);
    modport store (input  slot, row, col, wdata, we, dim_m, dim_n, dim_we);
endinterface

// Read side, used by the printer
interface mem_rd_if;
    matrix_pkg::slot_t slot;
    matrix_pkg::dim_t  row;
    matrix_pkg::dim_t  col;
    matrix_pkg::elem_t rdata;  // One cycle after address
    matrix_pkg::dim_t  dim_m;  // Combinational for slot
    matrix_pkg::dim_t  dim_n;

    modport reader (output slot, row, col, input  rdata, dim_m, dim_n);
    modport store  (input  slot, row, col, output rdata, dim_m, dim_n);
endinterface

// ==== matrix_pkg.sv ====
package matrix_pkg;

    // ----------------------------------------------------------
    // Basic types
    // ----------------------------------------------------------
    typedef logic [1:0]         slot_t;  // Matrix slot index
    typedef logic [2:0]         dim_t;   // Row/col count or index
    typedef logic signed [15:0] elem_t;  // Matrix element
    typedef logic [7:0]         byte_t;  // UART character

    // Dimension view of a parsed number, only low bits count
    typedef struct packed {
        logic [12:0] rsvd;
        dim_t        dim;
    } dim_word_t;

    // One parsed number, read as element or as dimension
    typedef union packed {
        elem_t     elem;  // Data phase
        dim_word_t dw;    // Dimension phase
    } num_word_u;

    // ----------------------------------------------------------
    // Character codes and print limits
    // ----------------------------------------------------------
    localparam byte_t CHAR_MINUS = 8'h2D;
    localparam byte_t CHAR_SPACE = 8'h20;
    localparam byte_t CHAR_ZERO  = 8'h30;

    localparam int MAX_DIGITS = 5;  // 32768 needs five

endpackage
